/* include/sinx_config.svh */
//--------------------------------------------------------------------
// sin(x) accelerator configuration
// word and fraction widths, series length and fixed latency
//--------------------------------------------------------------------

`ifndef SINX_CONFIG_SVH
`define SINX_CONFIG_SVH

// signed Q2.14 words
`define SINX_DATA_W  16
`define SINX_FRAC_W  14

// taylor terms x, x^3, x^5, x^7
`define SINX_N_TERMS 4

// edges from accepting edge until out_valid_o is high
`define SINX_LATENCY 16

`endif

/* source/sinx_fixed_pkg.sv */
//--------------------------------------------------------------------
// sin(x) fixed-point types
// Q2.14 words, full-width products and the term index
//--------------------------------------------------------------------

`include "sinx_config.svh"

package sinx_fixed_pkg;

  // one data word
  typedef logic signed [`SINX_DATA_W-1:0] sinx_fix_t;

  // full signed product of two words
  typedef logic signed [2*`SINX_DATA_W-1:0] sinx_wide_t;

  // series term index k
  typedef logic [$clog2(`SINX_N_TERMS)-1:0] sinx_term_idx_t;

  // 1.0 in the word format
  localparam sinx_fix_t FIX_ONE = sinx_fix_t'(1 << `SINX_FRAC_W);

  // index of the final term
  localparam sinx_term_idx_t LAST_TERM = sinx_term_idx_t'(`SINX_N_TERMS - 1);

endpackage

/* source/sinx_ctrl_pkg.sv */
//--------------------------------------------------------------------
// sin(x) controller encodings
// FSM states and multiplier operand selects
//--------------------------------------------------------------------

package sinx_ctrl_pkg;

  // controller states
  typedef enum logic [2:0] {
    ST_IDLE = 3'd0,
    ST_LOAD = 3'd1,
    ST_TERM = 3'd2,
    ST_ACC  = 3'd3,
    ST_POW1 = 3'd4,
    ST_POW2 = 3'd5,
    ST_DONE = 3'd6
  } sinx_state_e;

  // multiplier operand a
  typedef enum logic [1:0] {
    MUX_A_X   = 2'd0,
    MUX_A_POW = 2'd1,
    MUX_A_ONE = 2'd2
  } sinx_mux_a_e;

  // multiplier operand b
  typedef enum logic [1:0] {
    MUX_B_X    = 2'd0,
    MUX_B_LUT  = 2'd1,
    MUX_B_TERM = 2'd2
  } sinx_mux_b_e;

endpackage

/* source/sinx_dp_if.sv */
//--------------------------------------------------------------------
// sin(x) controller to datapath bundle
// register enables, accumulate mode, operand selects, ROM address
//--------------------------------------------------------------------

interface sinx_dp_if;

  import sinx_fixed_pkg::*;
  import sinx_ctrl_pkg::*;

  // register write enables
  logic           en_x;
  logic           en_pow;
  logic           en_term;
  logic           en_sum;

  // accumulate mode
  logic           sum_clr;
  logic           sub;

  // multiplier operand selects
  sinx_mux_a_e    mux_a;
  sinx_mux_b_e    mux_b;

  // coefficient ROM address
  sinx_term_idx_t term_idx;

  modport ctrl (
    output en_x, en_pow, en_term, en_sum, sum_clr, sub, mux_a, mux_b, term_idx
  );

  modport dp (
    input  en_x, en_pow, en_term, en_sum, sum_clr, sub, mux_a, mux_b, term_idx
  );

endinterface

/* source/sinx_lut.sv */
//--------------------------------------------------------------------
// sin(x) coefficient ROM
// holds 1/(2k+1)! for k = 0..3 in Q2.14
//--------------------------------------------------------------------

module sinx_lut (
  input  sinx_fixed_pkg::sinx_term_idx_t addr_i,
  output sinx_fixed_pkg::sinx_fix_t      data_o
);

  import sinx_fixed_pkg::*;

  always_comb begin
    case (addr_i)
      // 1/1!
      2'd0: data_o = FIX_ONE;
      // 1/3! rounded up from 2730.67
      2'd1: data_o = sinx_fix_t'(2731);
      // 1/5!
      2'd2: data_o = sinx_fix_t'(137);
      // 1/7!
      2'd3: data_o = sinx_fix_t'(3);
      default: begin
        data_o = '0;
      end
    endcase
  end

endmodule

/* source/sinx_dp.sv */
//--------------------------------------------------------------------
// sin(x) datapath
// operand, power, term and sum registers around one shared
// multiplier with Q2.14 rescaling
//--------------------------------------------------------------------

`include "sinx_config.svh"

module sinx_dp (
  input  logic                      clk_i,
  input  sinx_fixed_pkg::sinx_fix_t x_i,
  sinx_dp_if.dp                     ctrl,
  output sinx_fixed_pkg::sinx_fix_t result_o
);

  import sinx_fixed_pkg::*;
  import sinx_ctrl_pkg::*;

  // payload registers
  sinx_fix_t  x_q;
  sinx_fix_t  pow_q;
  sinx_fix_t  term_q;
  sinx_fix_t  sum_q;

  // multiplier signals
  sinx_fix_t  lut_data;
  sinx_fix_t  op_a;
  sinx_fix_t  op_b;
  sinx_wide_t prod_wide;
  sinx_fix_t  prod;

  //--------------------------------------------------------------------
  // coefficient ROM
  //--------------------------------------------------------------------

  sinx_lut u_lut (
    .addr_i (ctrl.term_idx),
    .data_o (lut_data)
  );

  //--------------------------------------------------------------------
  // shared multiplier
  //--------------------------------------------------------------------

  // operand a mux
  always_comb begin
    case (ctrl.mux_a)
      MUX_A_X:   op_a = x_q;
      MUX_A_POW: op_a = pow_q;
      MUX_A_ONE: op_a = FIX_ONE;
      default:   op_a = '0;
    endcase
  end

  // operand b mux
  always_comb begin
    case (ctrl.mux_b)
      MUX_B_X:    op_b = x_q;
      MUX_B_LUT:  op_b = lut_data;
      MUX_B_TERM: op_b = term_q;
      default:    op_b = '0;
    endcase
  end

  // full signed product
  assign prod_wide = sinx_wide_t'(op_a) * sinx_wide_t'(op_b);

  // back to Q2.14 by arithmetic shift
  // upper bits dropped without saturation
  assign prod = sinx_fix_t'(prod_wide >>> `SINX_FRAC_W);

  //--------------------------------------------------------------------
  // registers
  //--------------------------------------------------------------------

  // operand capture on the accepting edge
  always_ff @(posedge clk_i) begin
    if (ctrl.en_x) begin
      x_q <= x_i;
    end
  end

  // running odd power of x
  always_ff @(posedge clk_i) begin
    if (ctrl.en_pow) begin
      pow_q <= prod;
    end
  end

  // scaled term lut[k] * x^(2k+1)
  always_ff @(posedge clk_i) begin
    if (ctrl.en_term) begin
      term_q <= prod;
    end
  end

  // accumulator with wrapping add and subtract
  always_ff @(posedge clk_i) begin
    if (ctrl.en_sum) begin
      if (ctrl.sum_clr) begin
        sum_q <= '0;
      end else if (ctrl.sub) begin
        sum_q <= sum_q - prod;
      end else begin
        sum_q <= sum_q + prod;
      end
    end
  end

  assign result_o = sum_q;

endmodule

/* source/sinx_ctrl.sv */
//--------------------------------------------------------------------
// sin(x) controller
// FSM with term counter that sequences the datapath one step per
// cycle and runs the input and output handshakes
//--------------------------------------------------------------------

`include "sinx_config.svh"

module sinx_ctrl (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  output logic  out_valid_o,
  input  logic  out_ready_i,
  sinx_dp_if.ctrl dp
);

  import sinx_fixed_pkg::*;
  import sinx_ctrl_pkg::*;

  // state and term counter
  sinx_state_e    state_q;
  sinx_state_e    state_d;
  sinx_term_idx_t term_q;
  sinx_term_idx_t term_d;

  // output valid flag
  logic           out_valid_q;
  logic           out_valid_d;
  logic           out_take;

  // result consumed this cycle
  assign out_take = out_valid_q & out_ready_i;

  //--------------------------------------------------------------------
  // next state
  //--------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    term_d  = term_q;
    case (state_q)
      ST_IDLE: begin
        if (in_valid_i) begin
          state_d = ST_LOAD;
        end
      end
      ST_LOAD: begin
        // start at term k = 0
        state_d = ST_TERM;
        term_d  = '0;
      end
      ST_TERM: begin
        state_d = ST_ACC;
      end
      ST_ACC: begin
        // no power steps after the final term
        if (term_q == LAST_TERM) begin
          state_d = ST_DONE;
        end else begin
          state_d = ST_POW1;
          term_d  = term_q + 1'b1;
        end
      end
      ST_POW1: begin
        state_d = ST_POW2;
      end
      ST_POW2: begin
        state_d = ST_TERM;
      end
      ST_DONE: begin
        // hold until the consumer takes the result
        if (out_take) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  // valid rises one cycle after entering done
  // and drops on the output transfer
  assign out_valid_d = (state_q == ST_DONE) & ~out_take;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      term_q      <= '0;
      out_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      term_q      <= term_d;
      out_valid_q <= out_valid_d;
    end
  end

  //--------------------------------------------------------------------
  // datapath control decode
  //--------------------------------------------------------------------

  always_comb begin
    dp.en_x     = 1'b0;
    dp.en_pow   = 1'b0;
    dp.en_term  = 1'b0;
    dp.en_sum   = 1'b0;
    dp.sum_clr  = 1'b0;
    dp.sub      = 1'b0;
    dp.mux_a    = MUX_A_ONE;
    dp.mux_b    = MUX_B_X;
    dp.term_idx = term_q;
    case (state_q)
      // capture x on the accepting edge
      ST_IDLE: dp.en_x = in_valid_i;
      // power <= x * 1 and sum cleared
      ST_LOAD: begin
        dp.en_pow  = 1'b1;
        dp.en_sum  = 1'b1;
        dp.sum_clr = 1'b1;
        dp.mux_a   = MUX_A_ONE;
        dp.mux_b   = MUX_B_X;
      end
      // term <= lut[k] * power
      ST_TERM: begin
        dp.en_term = 1'b1;
        dp.mux_a   = MUX_A_POW;
        dp.mux_b   = MUX_B_LUT;
      end
      // odd k subtracts
      ST_ACC: begin
        dp.en_sum = 1'b1;
        dp.sub    = term_q[0];
        dp.mux_a  = MUX_A_ONE;
        dp.mux_b  = MUX_B_TERM;
      end
      // power <= x * power, twice per term
      ST_POW1, ST_POW2: begin
        dp.en_pow = 1'b1;
        dp.mux_a  = MUX_A_POW;
        dp.mux_b  = MUX_B_X;
      end
      default: begin
        dp.en_pow = 1'b0;
      end
    endcase
  end

  // handshake outputs
  assign in_ready_o  = (state_q == ST_IDLE);
  assign out_valid_o = out_valid_q;

endmodule

/* source/sinx_top.sv */
//--------------------------------------------------------------------
// sin(x) accelerator top level
// controller and datapath joined by the control bundle
//--------------------------------------------------------------------

module sinx_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // operand handshake
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  sinx_fixed_pkg::sinx_fix_t x_i,
  // result handshake
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output sinx_fixed_pkg::sinx_fix_t result_o
);

  // control bundle between controller and datapath
  sinx_dp_if dp_if ();

  //--------------------------------------------------------------------
  // controller
  //--------------------------------------------------------------------

  sinx_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .dp          (dp_if.ctrl)
  );

  //--------------------------------------------------------------------
  // datapath
  //--------------------------------------------------------------------

  sinx_dp u_dp (
    .clk_i    (clk_i),
    .x_i      (x_i),
    .ctrl     (dp_if.dp),
    .result_o (result_o)
  );

endmodule

/* test/sinx_checker.sv */
//--------------------------------------------------------------------
// sin(x) handshake checker
// mutual exclusion, output hold, fixed latency and reset state
//--------------------------------------------------------------------

`include "sinx_config.svh"

module sinx_checker (
  input logic                      clk_i,
  input logic                      rst_n_i,
  input logic                      in_valid_i,
  input logic                      in_ready_o,
  input logic                      out_valid_o,
  input logic                      out_ready_i,
  input sinx_fixed_pkg::sinx_fix_t result_o
);

  // edges counted since the last accepted operand
  logic       counting_q;
  logic [7:0] since_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      counting_q <= 1'b0;
      since_q    <= '0;
    end else if (in_valid_i && in_ready_o) begin
      counting_q <= 1'b1;
      since_q    <= '0;
    end else if (counting_q && !out_valid_o) begin
      since_q    <= since_q + 1'b1;
    end else if (out_valid_o) begin
      counting_q <= 1'b0;
    end
  end

  //--------------------------------------------------------------------
  // assertions
  //--------------------------------------------------------------------

  // busy accepting and offering a result never overlap
  ready_valid_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(in_ready_o && out_valid_o))
    else $error("in_ready_o and out_valid_o high together");

  // held result under back-pressure
  result_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(result_o)))
    else $error("result or out_valid_o changed while out_ready_i low");

  // result valid exactly the fixed number of edges after acceptance
  fixed_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(out_valid_o) |-> (counting_q && since_q == 8'(`SINX_LATENCY)))
    else $error("out_valid_o rose at the wrong distance from acceptance");

  // idle and empty right after reset
  reset_state: assert property (@(posedge clk_i)
    !rst_n_i |=> (in_ready_o && !out_valid_o))
    else $error("handshake outputs wrong after reset");

endmodule

bind sinx_top sinx_checker u_checker (.*);

/* test/sinx_tb.sv */
//--------------------------------------------------------------------
// sin(x) accelerator testbench
// directed, random, back-pressure and back-to-back operands against
// a bit-exact model of the series schedule
//--------------------------------------------------------------------

`include "sinx_config.svh"

module sinx_tb;

  import sinx_fixed_pkg::*;

  localparam int TIMEOUT = 100;

  logic      clk_i;
  logic      rst_n_i;
  logic      in_valid_i;
  logic      in_ready_o;
  sinx_fix_t x_i;
  logic      out_valid_o;
  logic      out_ready_i;
  sinx_fix_t result_o;
  logic [31:0] rng;
  sinx_fix_t got_pos;
  sinx_fix_t got_neg;
  sinx_fix_t got;
  sinx_fix_t ops[$];

  sinx_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    return v ^ (v << 5);
  endfunction

  // Q2.14 product, floor shift, wrap to one word
  function automatic sinx_fix_t fix_mul(input sinx_fix_t a, input sinx_fix_t b);
    sinx_wide_t p;
    p = sinx_wide_t'(a) * sinx_wide_t'(b);
    return sinx_fix_t'(p >>> `SINX_FRAC_W);
  endfunction

  // 1/(2k+1)! in Q2.14
  function automatic sinx_fix_t coef_of(input int k);
    case (k)
      0: return 16'sd16384;
      1: return 16'sd2731;
      2: return 16'sd137;
      default: return 16'sd3;
    endcase
  endfunction

  function automatic sinx_fix_t model_sin(input sinx_fix_t x);
    sinx_fix_t pw;
    sinx_fix_t term;
    sinx_fix_t sum;
    pw  = fix_mul(16'sd16384, x);
    sum = '0;
    for (int k = 0; k < `SINX_N_TERMS; k++) begin
      term = fix_mul(coef_of(k), pw);
      sum  = (k % 2 == 1) ? sinx_fix_t'(sum - term) : sinx_fix_t'(sum + term);
      if (k < `SINX_N_TERMS - 1) begin
        pw = fix_mul(x, fix_mul(x, pw));
      end
    end
    return sum;
  endfunction

  task automatic check_value(input string name, input sinx_fix_t exp, input sinx_fix_t act);
    assert (exp === act) else
      report_failure($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
  endtask

  // offer x and wait at falling edges until it is accepted
  task automatic send_operand(input sinx_fix_t x);
    int n;
    n = 0;
    in_valid_i = 1'b1;
    x_i = x;
    while (!in_ready_o) begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) report_failure("timeout waiting for in_ready_o");
    end
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic wait_result();
    int n;
    n = 0;
    while (!out_valid_o) begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) report_failure("timeout waiting for out_valid_o");
    end
  endtask

  // one operation with hold_cycles of back-pressure, offering a new operand meanwhile
  task automatic run_one(input string name, input sinx_fix_t x, input int hold_cycles,
                         output sinx_fix_t res);
    real diff;
    send_operand(x);
    in_valid_i = 1'b0;
    wait_result();
    res = result_o;
    for (int i = 0; i < hold_cycles; i++) begin
      in_valid_i = 1'b1;
      x_i = sinx_fix_t'(rng[15:0]);
      @(negedge clk_i);
      assert (!in_ready_o && out_valid_o) else
        report_failure("operand accepted or result lost under back-pressure");
      check_value({name, "_hold"}, res, result_o);
    end
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    @(negedge clk_i);
    out_ready_i = 1'b0;
    check_value(name, model_sin(x), res);
    // powers of x stay inside Q2.14 only below about 1.1
    if (x < 18000 && x > -18000) begin
      diff = $sin(real'(x) / 16384.0) - real'(res) / 16384.0;
      assert (diff < 0.01 && diff > -0.01) else
        report_failure($sformatf("[FAIL] %s_real expected %f actual %f", name,
                                 $sin(real'(x) / 16384.0), real'(res) / 16384.0));
    end
  endtask

  initial begin
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    x_i         = '0;
    rng         = 32'h1b79;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    assert (in_ready_o && !out_valid_o) else
      report_failure("handshake outputs wrong after reset");

    //------------------------------------------------------------------
    // directed operands
    //------------------------------------------------------------------
    run_one("zero", 16'sd0, 0, got);
    run_one("plus_one", 16'sd16384, 0, got_pos);
    run_one("minus_one", -16'sd16384, 0, got_neg);
    check_value("symmetry_one", sinx_fix_t'(-got_pos), got_neg);
    run_one("plus_half_pi", 16'sd25735, 0, got);
    run_one("minus_half_pi", -16'sd25735, 0, got);

    // random operands, some with back-pressure
    for (int i = 0; i < 200; i++) begin
      rng = xorshift(rng);
      run_one($sformatf("random_%0d", i), sinx_fix_t'(int'(rng % 32'd51471) - 25735),
              (i % 10 == 0) ? int'(rng[23:16] % 21) : 0, got);
    end

    //------------------------------------------------------------------
    // back-to-back with next operand already offered
    //------------------------------------------------------------------
    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      ops.push_back(sinx_fix_t'(int'(rng % 32'd51471) - 25735));
    end
    out_ready_i = 1'b1;
    for (int i = 0; i < 8; i++) begin
      send_operand(ops[i]);
      if (i < 7) x_i = ops[i + 1];
      else in_valid_i = 1'b0;
      wait_result();
      check_value($sformatf("b2b_%0d", i), model_sin(ops[i]), result_o);
      @(negedge clk_i);
    end
    out_ready_i = 1'b0;
    in_valid_i  = 1'b0;
    repeat (4) @(negedge clk_i);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* all.f */
+incdir+include
source/sinx_fixed_pkg.sv
source/sinx_ctrl_pkg.sv
source/sinx_dp_if.sv
source/sinx_lut.sv
source/sinx_dp.sv
source/sinx_ctrl.sv
source/sinx_top.sv
test/sinx_checker.sv
test/sinx_tb.sv

/* build.sh */
#!/bin/sh
# compile and run the sin(x) accelerator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wall -Wno-fatal -f all.f --top-module sinx_tb -Mdir obj_dir

# the log decides the verdict, so a failing run must not stop the script here
./obj_dir/Vsinx_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
exit 0
